//--- alu_operand_stage.sv
`timescale 1ns/1ps

module alu_operand_stage (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               vld,
   input  core_pkg::rob_idx_t idx,
   input  core_pkg::preg_t    dst,
   input  logic               reg_wrt,
   input  core_pkg::data_t    op1,
   input  core_pkg::data_t    op2,
   input  core_pkg::data_t    imm,
   input  logic               imm_vld,
   input  logic               ldi,
   input  logic               inv_rt,
   input  alu_pkg::alu_mode_t mode,
   output logic               ex_vld,
   output core_pkg::rob_idx_t ex_idx,
   output core_pkg::preg_t    ex_dst,
   output logic               ex_reg_wrt,
   output core_pkg::data_t    ex_a,
   output core_pkg::data_t    ex_b,
   output alu_pkg::alu_mode_t ex_mode
);

   core_pkg::data_t    rt_sel;
   core_pkg::data_t    a_nxt;
   core_pkg::data_t    b_nxt;
   alu_pkg::alu_mode_t mode_nxt;

   // immediate takes the place of rt
   assign rt_sel = imm_vld ? imm : op2;

   always_comb begin
      if (ldi) begin
         // ldi becomes imm + 0
         a_nxt    = imm;
         b_nxt    = '0;
         mode_nxt = alu_pkg::alu_add;
      end else begin
         a_nxt    = op1;
         b_nxt    = inv_rt ? ~rt_sel : rt_sel;
         mode_nxt = mode;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_vld <= 1'b0;
      end else begin
         ex_vld <= vld;
      end
   end

   // payload only moves with a valid issue
   always_ff @(posedge clk) begin
      if (vld) begin
         ex_idx     <= idx;
         ex_dst     <= dst;
         ex_reg_wrt <= reg_wrt;
         ex_a       <= a_nxt;
         ex_b       <= b_nxt;
         ex_mode    <= mode_nxt;
      end
   end

endmodule

//--- alu_pkg.sv
package alu_pkg;

   localparam int alu_mode_w = 3;

   // shifts only use the low bits of the second operand
   localparam int shamt_w = 4;

   typedef enum logic [alu_mode_w-1:0] {
      alu_add = 3'd0,
      alu_sub = 3'd1,
      alu_and = 3'd2,
      alu_or  = 3'd3,
      alu_xor = 3'd4,
      alu_shl = 3'd5,
      // logical shift with zero fill
      alu_shr = 3'd6,
      // signed compare giving 0 or 1
      alu_slt = 3'd7
   } alu_mode_t;

   // issue to done latency in cycles
   localparam int alu_lat  = 2;
   localparam int mult_lat = 3;

endpackage

//--- alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               vld,
   input  core_pkg::rob_idx_t idx,
   input  core_pkg::preg_t    dst,
   input  logic               reg_wrt,
   input  core_pkg::data_t    a,
   input  core_pkg::data_t    b,
   input  alu_pkg::alu_mode_t mode,
   output logic               done,
   output core_pkg::rob_idx_t done_idx,
   output core_pkg::data_t    result,
   output logic               wr_en,
   output core_pkg::preg_t    wr_addr
);

   core_pkg::data_t             alu_out;
   logic [alu_pkg::shamt_w-1:0] shamt;
   logic                        wrt_q;
   logic                        lt;

   assign shamt = b[alu_pkg::shamt_w-1:0];
   assign lt    = $signed(a) < $signed(b);

   always_comb begin
      case (mode)
         alu_pkg::alu_add: alu_out = a + b;
         alu_pkg::alu_sub: alu_out = a - b;
         alu_pkg::alu_and: alu_out = a & b;
         alu_pkg::alu_or:  alu_out = a | b;
         alu_pkg::alu_xor: alu_out = a ^ b;
         alu_pkg::alu_shl: alu_out = a << shamt;
         alu_pkg::alu_shr: alu_out = a >> shamt;
         alu_pkg::alu_slt: alu_out = {{(core_pkg::data_w-1){1'b0}}, lt};
         default:          alu_out = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         done <= 1'b0;
      end else begin
         done <= vld;
      end
   end

   always_ff @(posedge clk) begin
      if (vld) begin
         result   <= alu_out;
         done_idx <= idx;
         wr_addr  <= dst;
         wrt_q    <= reg_wrt;
      end
   end

   // done still fires when nothing is written
   assign wr_en = done & wrt_q;

endmodule

//--- core_pkg.sv
package core_pkg;

   // machine sizes
   localparam int data_w   = 16;
   localparam int preg_num = 64;
   localparam int preg_w   = 6;

   // reorder buffer is 64 deep
   localparam int rob_w    = 6;

   // one data word on every lane
   typedef logic [data_w-1:0] data_t;

   // physical register number
   typedef logic [preg_w-1:0] preg_t;

   // index handed back with each completion
   typedef logic [rob_w-1:0] rob_idx_t;

endpackage

//--- exec_backend.sv
`timescale 1ns/1ps

module exec_backend (
   input  logic               clk,
   input  logic               arst_n,
   // alu1 issue
   input  logic               alu1_vld,
   input  core_pkg::rob_idx_t alu1_idx,
   input  core_pkg::preg_t    alu1_dst, alu1_src1, alu1_src2,
   input  logic               alu1_reg_wrt,
   input  core_pkg::data_t    alu1_imm,
   input  logic               alu1_imm_vld, alu1_ldi, alu1_inv_rt,
   input  alu_pkg::alu_mode_t alu1_mode,
   // alu2 issue
   input  logic               alu2_vld,
   input  core_pkg::rob_idx_t alu2_idx,
   input  core_pkg::preg_t    alu2_dst, alu2_src1, alu2_src2,
   input  logic               alu2_reg_wrt,
   input  core_pkg::data_t    alu2_imm,
   input  logic               alu2_imm_vld, alu2_ldi, alu2_inv_rt,
   input  alu_pkg::alu_mode_t alu2_mode,
   // multiplier issue
   input  logic               mult_vld,
   input  core_pkg::rob_idx_t mult_idx,
   input  core_pkg::preg_t    mult_dst, mult_src1, mult_src2,
   input  logic               mult_reg_wrt,
   // completions
   output logic               alu1_done, alu2_done, mult_done,
   output core_pkg::rob_idx_t alu1_done_idx, alu2_done_idx, mult_done_idx,
   output core_pkg::data_t    alu1_result, alu2_result, mult_result
);

   // register file read data
   core_pkg::data_t    alu1_op1, alu1_op2, alu2_op1, alu2_op2, mult_op1, mult_op2;

   // operand stage to ALU
   logic               alu1_ex_vld, alu2_ex_vld;
   core_pkg::rob_idx_t alu1_ex_idx, alu2_ex_idx;
   core_pkg::preg_t    alu1_ex_dst, alu2_ex_dst;
   logic               alu1_ex_wrt, alu2_ex_wrt;
   core_pkg::data_t    alu1_ex_a, alu1_ex_b, alu2_ex_a, alu2_ex_b;
   alu_pkg::alu_mode_t alu1_ex_mode, alu2_ex_mode;

   // write back
   logic               alu1_wr_en, alu2_wr_en, mult_wr_en;
   core_pkg::preg_t    alu1_wr_addr, alu2_wr_addr, mult_wr_addr;

   phys_reg_file rf0 (
      .clk(clk), .arst_n(arst_n),
      .alu1_rs1(alu1_src1), .alu1_rs2(alu1_src2),
      .alu2_rs1(alu2_src1), .alu2_rs2(alu2_src2),
      .mult_rs1(mult_src1), .mult_rs2(mult_src2),
      .alu1_op1(alu1_op1), .alu1_op2(alu1_op2),
      .alu2_op1(alu2_op1), .alu2_op2(alu2_op2),
      .mult_op1(mult_op1), .mult_op2(mult_op2),
      .alu1_wr_en(alu1_wr_en), .alu1_wr_addr(alu1_wr_addr), .alu1_wr_data(alu1_result),
      .alu2_wr_en(alu2_wr_en), .alu2_wr_addr(alu2_wr_addr), .alu2_wr_data(alu2_result),
      .mult_wr_en(mult_wr_en), .mult_wr_addr(mult_wr_addr), .mult_wr_data(mult_result)
   );

   alu_operand_stage alu1_opnd (
      .clk(clk), .arst_n(arst_n),
      .vld(alu1_vld), .idx(alu1_idx), .dst(alu1_dst), .reg_wrt(alu1_reg_wrt),
      .op1(alu1_op1), .op2(alu1_op2), .imm(alu1_imm), .imm_vld(alu1_imm_vld),
      .ldi(alu1_ldi), .inv_rt(alu1_inv_rt), .mode(alu1_mode),
      .ex_vld(alu1_ex_vld), .ex_idx(alu1_ex_idx), .ex_dst(alu1_ex_dst),
      .ex_reg_wrt(alu1_ex_wrt), .ex_a(alu1_ex_a), .ex_b(alu1_ex_b), .ex_mode(alu1_ex_mode)
   );

   alu_operand_stage alu2_opnd (
      .clk(clk), .arst_n(arst_n),
      .vld(alu2_vld), .idx(alu2_idx), .dst(alu2_dst), .reg_wrt(alu2_reg_wrt),
      .op1(alu2_op1), .op2(alu2_op2), .imm(alu2_imm), .imm_vld(alu2_imm_vld),
      .ldi(alu2_ldi), .inv_rt(alu2_inv_rt), .mode(alu2_mode),
      .ex_vld(alu2_ex_vld), .ex_idx(alu2_ex_idx), .ex_dst(alu2_ex_dst),
      .ex_reg_wrt(alu2_ex_wrt), .ex_a(alu2_ex_a), .ex_b(alu2_ex_b), .ex_mode(alu2_ex_mode)
   );

   alu_unit alu1 (
      .clk(clk), .arst_n(arst_n),
      .vld(alu1_ex_vld), .idx(alu1_ex_idx), .dst(alu1_ex_dst), .reg_wrt(alu1_ex_wrt),
      .a(alu1_ex_a), .b(alu1_ex_b), .mode(alu1_ex_mode),
      .done(alu1_done), .done_idx(alu1_done_idx), .result(alu1_result),
      .wr_en(alu1_wr_en), .wr_addr(alu1_wr_addr)
   );

   alu_unit alu2 (
      .clk(clk), .arst_n(arst_n),
      .vld(alu2_ex_vld), .idx(alu2_ex_idx), .dst(alu2_ex_dst), .reg_wrt(alu2_ex_wrt),
      .a(alu2_ex_a), .b(alu2_ex_b), .mode(alu2_ex_mode),
      .done(alu2_done), .done_idx(alu2_done_idx), .result(alu2_result),
      .wr_en(alu2_wr_en), .wr_addr(alu2_wr_addr)
   );

   // multiplier takes register data straight from the file
   mult_unit mult0 (
      .clk(clk), .arst_n(arst_n),
      .vld(mult_vld), .idx(mult_idx), .dst(mult_dst), .reg_wrt(mult_reg_wrt),
      .op1(mult_op1), .op2(mult_op2),
      .done(mult_done), .done_idx(mult_done_idx), .result(mult_result),
      .wr_en(mult_wr_en), .wr_addr(mult_wr_addr)
   );

endmodule

//--- exec_input.txt
# lane same idx dst src1 src2 imm imm_vld ldi inv_rt mode reg_wrt expected, all hex
# lane 0 idle, 1 alu1, 2 alu2, 3 mult; same 1 issues together with the next line
1 1 01 00 0a 0b 0000 0 0 0 0 0 0000
3 0 02 00 20 3f 0000 0 0 0 0 0 0000
1 1 03 01 00 00 1234 0 1 0 0 1 1234
2 0 04 02 00 00 0f0f 0 1 0 0 1 0f0f
1 1 05 03 00 00 8001 0 1 0 0 1 8001
2 0 06 04 00 00 0013 0 1 0 0 1 0013
0 0 00 00 00 00 0000 0 0 0 0 0 0000
0 0 00 00 00 00 0000 0 0 0 0 0 0000
1 1 07 05 01 02 0000 0 0 0 0 1 2143
2 0 08 00 01 00 0100 1 0 1 0 0 1133
1 1 09 06 01 02 0000 0 0 0 1 1 0325
2 0 0a 00 02 00 0010 1 0 0 1 0 0eff
1 1 0b 00 01 02 0000 0 0 0 2 0 0204
2 0 0c 00 01 02 0000 0 0 1 2 0 1030
1 1 0d 00 02 03 0000 0 0 0 3 0 8f0f
2 0 0e 00 03 00 00f0 1 0 1 3 0 ff0f
1 1 0f 00 01 02 0000 0 0 0 4 0 1d3b
2 0 10 00 01 00 ffff 1 0 0 4 0 edcb
1 1 11 00 01 04 0000 0 0 0 5 0 91a0
2 0 12 00 02 00 0024 1 0 0 5 0 f0f0
1 1 13 00 03 04 0000 0 0 0 6 0 1000
2 0 14 00 01 00 fffd 1 0 1 6 0 048d
1 1 15 00 03 02 0000 0 0 0 7 0 0001
2 0 16 00 01 00 fff0 1 0 0 7 0 0000
1 1 17 01 00 00 5555 0 1 0 0 0 5555
3 0 18 07 01 02 0000 0 0 0 0 1 1d0c
3 0 19 00 05 06 0000 0 0 0 0 0 97af
1 1 1a 00 05 06 0000 0 0 0 0 0 2468
2 1 1b 00 02 04 0000 0 0 0 1 0 0efc
3 0 1c 00 03 04 0000 0 0 0 0 0 8013
0 0 00 00 00 00 0000 0 0 0 0 0 0000
0 0 00 00 00 00 0000 0 0 0 0 0 0000
0 0 00 00 00 00 0000 0 0 0 0 0 0000
1 1 1d 00 01 00 0000 1 0 0 0 0 1234
2 0 1e 00 07 0a 0000 0 0 0 0 0 1d0c

//--- mult_unit.sv
`timescale 1ns/1ps

module mult_unit (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               vld,
   input  core_pkg::rob_idx_t idx,
   input  core_pkg::preg_t    dst,
   input  logic               reg_wrt,
   input  core_pkg::data_t    op1,
   input  core_pkg::data_t    op2,
   output logic               done,
   output core_pkg::rob_idx_t done_idx,
   output core_pkg::data_t    result,
   output logic               wr_en,
   output core_pkg::preg_t    wr_addr
);

   // operand capture stage
   logic               s1_vld;
   core_pkg::rob_idx_t s1_idx;
   core_pkg::preg_t    s1_dst;
   logic               s1_wrt;
   core_pkg::data_t    s1_a;
   core_pkg::data_t    s1_b;

   // product stage
   logic               s2_vld;
   core_pkg::rob_idx_t s2_idx;
   core_pkg::preg_t    s2_dst;
   logic               s2_wrt;
   core_pkg::data_t    s2_prod;

   logic               out_wrt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_vld <= 1'b0;
         s2_vld <= 1'b0;
         done   <= 1'b0;
      end else begin
         s1_vld <= vld;
         s2_vld <= s1_vld;
         done   <= s2_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (vld) begin
         s1_idx <= idx;
         s1_dst <= dst;
         s1_wrt <= reg_wrt;
         s1_a   <= op1;
         s1_b   <= op2;
      end
      if (s1_vld) begin
         s2_idx  <= s1_idx;
         s2_dst  <= s1_dst;
         s2_wrt  <= s1_wrt;
         // only the low half of the product is kept
         s2_prod <= s1_a * s1_b;
      end
      if (s2_vld) begin
         done_idx <= s2_idx;
         wr_addr  <= s2_dst;
         out_wrt  <= s2_wrt;
         result   <= s2_prod;
      end
   end

   assign wr_en = done & out_wrt;

endmodule

//--- phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file (
   input  logic            clk,
   input  logic            arst_n,
   // two read addresses per lane
   input  core_pkg::preg_t alu1_rs1,
   input  core_pkg::preg_t alu1_rs2,
   input  core_pkg::preg_t alu2_rs1,
   input  core_pkg::preg_t alu2_rs2,
   input  core_pkg::preg_t mult_rs1,
   input  core_pkg::preg_t mult_rs2,
   output core_pkg::data_t alu1_op1,
   output core_pkg::data_t alu1_op2,
   output core_pkg::data_t alu2_op1,
   output core_pkg::data_t alu2_op2,
   output core_pkg::data_t mult_op1,
   output core_pkg::data_t mult_op2,
   // write back from the three units
   input  logic            alu1_wr_en,
   input  core_pkg::preg_t alu1_wr_addr,
   input  core_pkg::data_t alu1_wr_data,
   input  logic            alu2_wr_en,
   input  core_pkg::preg_t alu2_wr_addr,
   input  core_pkg::data_t alu2_wr_data,
   input  logic            mult_wr_en,
   input  core_pkg::preg_t mult_wr_addr,
   input  core_pkg::data_t mult_wr_data
);

   core_pkg::data_t regs [core_pkg::preg_num];

   // writers never target one register in the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < core_pkg::preg_num; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (alu1_wr_en) begin
            regs[alu1_wr_addr] <= alu1_wr_data;
         end
         if (alu2_wr_en) begin
            regs[alu2_wr_addr] <= alu2_wr_data;
         end
         if (mult_wr_en) begin
            regs[mult_wr_addr] <= mult_wr_data;
         end
      end
   end

   // async reads see the old value in a write cycle
   assign alu1_op1 = regs[alu1_rs1];
   assign alu1_op2 = regs[alu1_rs2];
   assign alu2_op1 = regs[alu2_rs1];
   assign alu2_op2 = regs[alu2_rs2];
   assign mult_op1 = regs[mult_rs1];
   assign mult_op2 = regs[mult_rs2];

endmodule

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exec_backend -f sim.f -o sim_exec
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_exec > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
fi

if grep -F -q "*** TEST PASSED ***" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim.f
core_pkg.sv
alu_pkg.sv
phys_reg_file.sv
alu_operand_stage.sv
alu_unit.sv
mult_unit.sv
exec_backend.sv
tb_exec_backend.sv

//--- tb_exec_backend.sv
`timescale 1ns/1ps

module tb_exec_backend;

   localparam int max_recs   = 64;
   localparam int n_fields   = 13;
   localparam int clk_ns     = 4;
   localparam int rst_cycles = 3;

   // columns of one record in the input file
   typedef enum int {
      f_lane, f_same, f_idx, f_dst, f_src1, f_src2, f_imm, f_immv, f_ldi, f_inv, f_mode,
      f_wrt, f_exp
   } field_t;

   typedef struct packed {
      logic [31:0]        cyc;
      core_pkg::rob_idx_t idx;
      core_pkg::data_t    res;
   } pending_t;

   logic               clk, arst_n;
   logic               alu1_vld, alu2_vld, mult_vld;
   core_pkg::rob_idx_t alu1_idx, alu2_idx, mult_idx;
   core_pkg::preg_t    alu1_dst, alu1_src1, alu1_src2, alu2_dst, alu2_src1, alu2_src2;
   core_pkg::preg_t    mult_dst, mult_src1, mult_src2;
   logic               alu1_reg_wrt, alu2_reg_wrt, mult_reg_wrt;
   core_pkg::data_t    alu1_imm, alu2_imm;
   logic               alu1_imm_vld, alu1_ldi, alu1_inv_rt, alu2_imm_vld, alu2_ldi, alu2_inv_rt;
   alu_pkg::alu_mode_t alu1_mode, alu2_mode;
   logic               alu1_done, alu2_done, mult_done;
   core_pkg::rob_idx_t alu1_done_idx, alu2_done_idx, mult_done_idx;
   core_pkg::data_t    alu1_result, alu2_result, mult_result;

   int unsigned rec [max_recs][n_fields];
   int          n_recs;
   int          cyc;
   logic        loaded;
   pending_t    alu1_q[$], alu2_q[$], mult_q[$];

   exec_backend dut0 (.*);

   initial clk = 1'b0;
   always #(clk_ns / 2) clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string name, input core_pkg::data_t got,
                             input core_pkg::data_t exp);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_idx(input string name, input core_pkg::rob_idx_t got,
                            input core_pkg::rob_idx_t exp);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // one lane's done strobe against the oldest pending completion
   task automatic match_done(input string lane, input logic done,
                             input core_pkg::rob_idx_t idx, input core_pkg::data_t res,
                             ref pending_t q[$]);
      logic due;
      due = (q.size() > 0) && (q[0].cyc == cyc);
      if (done && !due) begin
         stop_run($sformatf("%s signalled done in cycle %0d with nothing due", lane, cyc));
      end else if (!done && due) begin
         stop_run($sformatf("%s did not signal done in cycle %0d", lane, cyc));
      end else if (done) begin
         check_idx({lane, "_done_idx"}, idx, q[0].idx);
         check_data({lane, "_result"}, res, q[0].res);
         void'(q.pop_front());
      end
   endtask

   task automatic next_cycle();
      @(negedge clk);
      cyc++;
      match_done("alu1", alu1_done, alu1_done_idx, alu1_result, alu1_q);
      match_done("alu2", alu2_done, alu2_done_idx, alu2_result, alu2_q);
      match_done("mult", mult_done, mult_done_idx, mult_result, mult_q);
      alu1_vld = 1'b0;
      alu2_vld = 1'b0;
      mult_vld = 1'b0;
   endtask

   task automatic issue_record(input int i);
      pending_t p;
      p.idx = core_pkg::rob_idx_t'(rec[i][f_idx]);
      p.res = core_pkg::data_t'(rec[i][f_exp]);
      case (rec[i][f_lane])
         1: begin
            alu1_vld     = 1'b1;
            alu1_idx     = p.idx;
            alu1_dst     = core_pkg::preg_t'(rec[i][f_dst]);
            alu1_src1    = core_pkg::preg_t'(rec[i][f_src1]);
            alu1_src2    = core_pkg::preg_t'(rec[i][f_src2]);
            alu1_imm     = core_pkg::data_t'(rec[i][f_imm]);
            alu1_imm_vld = rec[i][f_immv][0];
            alu1_ldi     = rec[i][f_ldi][0];
            alu1_inv_rt  = rec[i][f_inv][0];
            alu1_mode    = alu_pkg::alu_mode_t'(rec[i][f_mode][2:0]);
            alu1_reg_wrt = rec[i][f_wrt][0];
            p.cyc = cyc + alu_pkg::alu_lat;
            alu1_q.push_back(p);
         end
         2: begin
            alu2_vld     = 1'b1;
            alu2_idx     = p.idx;
            alu2_dst     = core_pkg::preg_t'(rec[i][f_dst]);
            alu2_src1    = core_pkg::preg_t'(rec[i][f_src1]);
            alu2_src2    = core_pkg::preg_t'(rec[i][f_src2]);
            alu2_imm     = core_pkg::data_t'(rec[i][f_imm]);
            alu2_imm_vld = rec[i][f_immv][0];
            alu2_ldi     = rec[i][f_ldi][0];
            alu2_inv_rt  = rec[i][f_inv][0];
            alu2_mode    = alu_pkg::alu_mode_t'(rec[i][f_mode][2:0]);
            alu2_reg_wrt = rec[i][f_wrt][0];
            p.cyc = cyc + alu_pkg::alu_lat;
            alu2_q.push_back(p);
         end
         default: begin
            mult_vld     = 1'b1;
            mult_idx     = p.idx;
            mult_dst     = core_pkg::preg_t'(rec[i][f_dst]);
            mult_src1    = core_pkg::preg_t'(rec[i][f_src1]);
            mult_src2    = core_pkg::preg_t'(rec[i][f_src2]);
            mult_reg_wrt = rec[i][f_wrt][0];
            p.cyc = cyc + alu_pkg::mult_lat;
            mult_q.push_back(p);
         end
      endcase
   endtask

   task automatic load_records();
      int          fd;
      string       line;
      int unsigned v [n_fields];
      fd = $fopen("exec_input.txt", "r");
      if (fd == 0) begin
         stop_run("could not open exec_input.txt");
      end else begin
         n_recs = 0;
         // comment lines scan to nothing
         while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                        v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                        v[12]) == n_fields) begin
               rec[n_recs] = v;
               n_recs++;
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      wait (loaded);
      #((n_recs + 20) * clk_ns + rst_cycles * clk_ns);
      stop_run("timeout, the run did not finish in time");
   end

   initial begin
      int ri;
      int gap;
      bit more;
      void'($urandom(10510));
      arst_n = 1'b0;
      cyc    = 0;
      loaded = 1'b0;
      {alu1_vld, alu1_idx, alu1_dst, alu1_src1, alu1_src2, alu1_reg_wrt, alu1_imm,
       alu1_imm_vld, alu1_ldi, alu1_inv_rt} = '0;
      {alu2_vld, alu2_idx, alu2_dst, alu2_src1, alu2_src2, alu2_reg_wrt, alu2_imm,
       alu2_imm_vld, alu2_ldi, alu2_inv_rt} = '0;
      {mult_vld, mult_idx, mult_dst, mult_src1, mult_src2, mult_reg_wrt} = '0;
      alu1_mode = alu_pkg::alu_add;
      alu2_mode = alu_pkg::alu_add;
      load_records();
      loaded = 1'b1;
      repeat (rst_cycles) @(negedge clk);
      arst_n = 1'b1;
      ri = 0;
      while (ri < n_recs) begin
         next_cycle();
         if (rec[ri][f_lane] == 0) begin
            // idle stretch between sections
            gap = 1 + int'($urandom % 2);
            repeat (gap - 1) next_cycle();
            ri++;
         end else begin
            more = 1'b1;
            while (more) begin
               issue_record(ri);
               more = rec[ri][f_same] != 0;
               ri++;
            end
         end
      end
      repeat (alu_pkg::mult_lat + 2) next_cycle();
      if (alu1_q.size() == 0 && alu2_q.size() == 0 && mult_q.size() == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         stop_run("completions still outstanding at the end of the run");
      end
   end

endmodule
